//--- rtl/snn_cfg_pkg.sv
/*
 * sizing constants for the synapse accumulate block
 * connection count, address, weight and index widths
 */
`default_nettype none

package snn_cfg_pkg;

    // synapses feeding one unit
    localparam int num_connections = 5;

    // spike source address width
    localparam int addr_width = 12;

    // ieee single precision weight
    localparam int weight_width = 32;

    // wide enough to index every connection
    localparam int conn_idx_width = 3;

    // float field layout for the adder
    localparam int exp_width = 8;
    localparam int man_width = 23;

endpackage : snn_cfg_pkg

`default_nettype wire

//--- rtl/snn_types_pkg.sv
/*
 * shared structs for table entries, config writes and results
 * plus the sequencer state encoding
 */
`default_nettype none

package snn_types_pkg;

    import snn_cfg_pkg::*;

    // one connection of the synapse table
    typedef struct packed {
        logic                    valid;
        logic [addr_width-1:0]   src_addr;
        logic [weight_width-1:0] weight;
    } synapse_entry_t;

    // config port word with index and new entry
    typedef struct packed {
        logic [conn_idx_width-1:0] idx;
        synapse_entry_t            entry;
    } cfg_write_t;

    // one bit per connection
    typedef logic [num_connections-1:0] spike_vec_t;

    // weighted sum of one timestep
    typedef struct packed {
        logic [weight_width-1:0] sum;
        logic                    overflow;
    } mac_result_t;

    // accumulate sequencer
    typedef enum logic [1:0] {
        idle,
        accumulate,
        report
    } mac_state_t;

endpackage : snn_types_pkg

`default_nettype wire

//--- rtl/synapse_table.sv
/*
 * synapse table with config write port
 * parallel source address match into a hit vector
 */
`timescale 1ns/1ps
`default_nettype none

module synapse_table
    import snn_cfg_pkg::*;
    import snn_types_pkg::*;
(
    input  logic                                          clear_mac17,
    input  logic                                          rst_n,
    input  logic                                          cfg_we,
    input  cfg_write_t                                    cfg,
    input  logic                                          spike_valid,
    input  logic [addr_width-1:0]                         spike_addr,
    output spike_vec_t                                    hit,
    output logic [num_connections-1:0][weight_width-1:0] weights
);

    // per connection storage
    logic [num_connections-1:0]                   valid_q;
    logic [addr_width-1:0]                        addr_q [num_connections];
    logic [num_connections-1:0][weight_width-1:0] weight_q;

    // out of range index is dropped
    logic cfg_hit_range;

    assign cfg_hit_range = cfg_we && (cfg.idx < conn_idx_width'(num_connections));

    // valid bits per connection
    always_ff @(posedge clear_mac17) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (cfg_hit_range) begin
            valid_q[cfg.idx] <= cfg.entry.valid;
        end
    end

    // address and weight payload
    always_ff @(posedge clear_mac17) begin
        if (cfg_hit_range) begin
            addr_q[cfg.idx]   <= cfg.entry.src_addr;
            weight_q[cfg.idx] <= cfg.entry.weight;
        end
    end

    // compare against every entry at once
    // duplicate addresses light several bits
    always_comb begin
        for (int i = 0; i < num_connections; i++) begin
            hit[i] = spike_valid && valid_q[i] && (addr_q[i] == spike_addr);
        end
    end

    assign weights = weight_q;

endmodule : synapse_table

`default_nettype wire

//--- rtl/spike_collector.sv
/*
 * incoming spike set with freeze at timestep end
 * double buffered so the next timestep keeps its spikes
 */
`timescale 1ns/1ps
`default_nettype none

module spike_collector
    import snn_types_pkg::*;
(
    input  logic       clear_mac17,
    input  logic       rst_n,
    input  spike_vec_t hit,
    input  logic       timestep_end,
    input  logic       busy,
    output spike_vec_t frozen_spikes,
    output logic       start
);

    spike_vec_t incoming_q;
    logic       accept;

    // timestep end is lost while the accumulator runs
    assign accept = timestep_end && !busy;

    always_ff @(posedge clear_mac17) begin
        if (!rst_n) begin
            incoming_q    <= '0;
            frozen_spikes <= '0;
            start         <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                // same cycle hit belongs to the new timestep
                frozen_spikes <= incoming_q;
                incoming_q    <= hit;
            end else begin
                incoming_q <= incoming_q | hit;
            end
        end
    end

endmodule : spike_collector

`default_nettype wire

//--- rtl/fp_adder.sv
/*
 * combinational single precision adder for non-negative operands
 * truncating with overflow to +inf
 */
`timescale 1ns/1ps
`default_nettype none

module fp_adder
    import snn_cfg_pkg::*;
(
    input  logic [weight_width-1:0] a,
    input  logic [weight_width-1:0] b,
    output logic [weight_width-1:0] sum,
    output logic                    overflow
);

    // all-ones exponent means infinity
    localparam logic [exp_width:0] exp_inf = {1'b0, {exp_width{1'b1}}};

    // field split without the sign bit
    logic [exp_width-1:0] a_exp;
    logic [exp_width-1:0] b_exp;
    logic [man_width-1:0] a_man;
    logic [man_width-1:0] b_man;
    logic                 a_zero;
    logic                 b_zero;

    // operand ordering by exponent
    logic                 a_big;
    logic [exp_width-1:0] big_exp;
    logic [exp_width-1:0] small_exp;
    logic [man_width:0]   big_man;
    logic [man_width:0]   small_man;
    logic [exp_width-1:0] exp_diff;

    // aligned add with one bit of headroom for the carry
    logic [man_width:0]   small_aligned;
    logic [man_width+1:0] man_sum;

    // pre-saturation result with one extra exponent bit
    logic [exp_width:0]   exp_res;
    logic [man_width-1:0] man_res;

    assign a_exp = a[weight_width-2 -: exp_width];
    assign b_exp = b[weight_width-2 -: exp_width];
    assign a_man = a[man_width-1:0];
    assign b_man = b[man_width-1:0];

    // without subnormals a zero exponent means zero
    assign a_zero = (a_exp == '0);
    assign b_zero = (b_exp == '0);

    assign a_big     = (a_exp >= b_exp);
    assign big_exp   = a_big ? a_exp : b_exp;
    assign small_exp = a_big ? b_exp : a_exp;
    // hidden one restored
    assign big_man   = a_big ? {1'b1, a_man} : {1'b1, b_man};
    assign small_man = a_big ? {1'b1, b_man} : {1'b1, a_man};
    assign exp_diff  = big_exp - small_exp;

    // shifted out bits are dropped and large gaps give zero
    assign small_aligned = small_man >> exp_diff;
    assign man_sum       = {1'b0, big_man} + {1'b0, small_aligned};

    always_comb begin
        if (a_zero) begin
            exp_res = {1'b0, b_exp};
            man_res = b_man;
        end else if (b_zero) begin
            exp_res = {1'b0, a_exp};
            man_res = a_man;
        end else if (man_sum[man_width+1]) begin
            // carry out shifts right once and drops the lsb
            exp_res = {1'b0, big_exp} + 1'b1;
            man_res = man_sum[man_width:1];
        end else begin
            exp_res = {1'b0, big_exp};
            man_res = man_sum[man_width-1:0];
        end
    end

    // saturate to +inf once the exponent hits all ones
    assign overflow = (exp_res >= exp_inf);
    assign sum = overflow ? {1'b0, exp_inf[exp_width-1:0], {man_width{1'b0}}}
                          : {1'b0, exp_res[exp_width-1:0], man_res};

endmodule : fp_adder

`default_nettype wire

//--- rtl/mac_accumulator.sv
/*
 * sequencer that walks the frozen spikes one connection per cycle
 * accumulates weights through the float adder, reports with done
 */
`timescale 1ns/1ps
`default_nettype none

module mac_accumulator
    import snn_cfg_pkg::*;
    import snn_types_pkg::*;
(
    input  logic                                          clear_mac17,
    input  logic                                          rst_n,
    input  logic                                          start,
    input  spike_vec_t                                    frozen_spikes,
    input  logic [num_connections-1:0][weight_width-1:0] weights,
    output logic                                          busy,
    output logic                                          done,
    output mac_result_t                                   result
);

    localparam logic [conn_idx_width-1:0] last_idx = conn_idx_width'(num_connections - 1);

    mac_state_t                state;
    logic [conn_idx_width-1:0] idx;
    logic [weight_width-1:0]   acc;
    logic                      ovf_sticky;

    // adder hookup
    logic [weight_width-1:0]   addend;
    logic [weight_width-1:0]   add_sum;
    logic                      add_ovf;

    // silent connections add zero
    assign addend = frozen_spikes[idx] ? weights[idx] : '0;

    fp_adder u_fp_adder (
        .a        (acc),
        .b        (addend),
        .sum      (add_sum),
        .overflow (add_ovf)
    );

    // start counts as busy so a back to back timestep end is refused
    assign busy = start || (state != idle);

    // running sum cleared when a timestep is taken
    always_ff @(posedge clear_mac17) begin
        if (state == idle && start) begin
            acc <= '0;
        end else if (state == accumulate) begin
            acc <= add_sum;
        end
    end

    always_ff @(posedge clear_mac17) begin
        if (!rst_n) begin
            state      <= idle;
            idx        <= '0;
            ovf_sticky <= 1'b0;
            done       <= 1'b0;
            result     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        idx        <= '0;
                        ovf_sticky <= 1'b0;
                        state      <= accumulate;
                    end
                end
                accumulate: begin
                    ovf_sticky <= ovf_sticky | add_ovf;
                    idx        <= idx + 1'b1;
                    // last connection added this cycle
                    if (idx == last_idx) begin
                        state <= report;
                    end
                end
                report: begin
                    result.sum      <= acc;
                    result.overflow <= ovf_sticky;
                    done            <= 1'b1;
                    state           <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule : mac_accumulator

`default_nettype wire

//--- rtl/snn_mac_top.sv
/*
 * synapse accumulate block top
 * table, spike collector and accumulator
 */
`timescale 1ns/1ps
`default_nettype none

module snn_mac_top
    import snn_cfg_pkg::*;
    import snn_types_pkg::*;
(
    input  logic                  clear_mac17,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  cfg_write_t            cfg,
    input  logic                  spike_valid,
    input  logic [addr_width-1:0] spike_addr,
    input  logic                  timestep_end,
    output logic                  done,
    output mac_result_t           result
);

    // table to collector and accumulator
    spike_vec_t                                    hit;
    logic [num_connections-1:0][weight_width-1:0] weights;

    // collector to accumulator and back
    spike_vec_t frozen_spikes;
    logic       start;
    logic       busy;

    synapse_table u_synapse_table (
        .clear_mac17 (clear_mac17),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg         (cfg),
        .spike_valid (spike_valid),
        .spike_addr  (spike_addr),
        .hit         (hit),
        .weights     (weights)
    );

    spike_collector u_spike_collector (
        .clear_mac17   (clear_mac17),
        .rst_n         (rst_n),
        .hit           (hit),
        .timestep_end  (timestep_end),
        .busy          (busy),
        .frozen_spikes (frozen_spikes),
        .start         (start)
    );

    mac_accumulator u_mac_accumulator (
        .clear_mac17   (clear_mac17),
        .rst_n         (rst_n),
        .start         (start),
        .frozen_spikes (frozen_spikes),
        .weights       (weights),
        .busy          (busy),
        .done          (done),
        .result        (result)
    );

endmodule : snn_mac_top

`default_nettype wire

//--- verification/snn_mac_tb.sv
/*
 * table driven testbench for the synapse accumulate block
 * fixed rows, random spike subsets, timeout watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module snn_mac_tb
    import snn_cfg_pkg::*;
    import snn_types_pkg::*;
();

    typedef int addr_list_t [$];

    localparam int num_rows       = 13;
    localparam int max_spikes     = 5;
    localparam int num_random     = 12;
    localparam int reset_cycles   = 4;
    localparam int cycles_per_row = 20;
    // three table loads of up to six writes each plus the post reset check
    localparam int cfg_cycles     = 3 * (num_connections + 1) + 2;
    localparam int timeout_cycles = reset_cycles + cfg_cycles
                                    + (num_rows + num_random) * cycles_per_row;

    logic                  clear_mac17 = 1'b0;
    logic                  rst_n;
    logic                  cfg_we;
    cfg_write_t            cfg;
    logic                  spike_valid;
    logic [addr_width-1:0] spike_addr;
    logic                  timestep_end;
    logic                  done;
    mac_result_t           result;

    // stimulus table where -1 marks an unused spike slot
    string       row_name   [num_rows];
    int          row_cfg    [num_rows];
    int          row_spikes [num_rows][max_spikes];
    int          row_end    [num_rows];
    int          row_busy   [num_rows];
    mac_result_t row_exp    [num_rows];
    int          row_total = 0;

    // set 1 weights in units of 0.25 for the subset lookup
    int          set1_quarters [num_connections] = '{6, 9, 2, 16, 32};
    logic [31:0] subset_sum [32];

    integer seed = 32'h6a83_2e1b;
    int     cycle_count = 0;

    snn_mac_top u_snn_mac_top (
        .clear_mac17  (clear_mac17),
        .rst_n        (rst_n),
        .cfg_we       (cfg_we),
        .cfg          (cfg),
        .spike_valid  (spike_valid),
        .spike_addr   (spike_addr),
        .timestep_end (timestep_end),
        .done         (done),
        .result       (result)
    );

    always #4 clear_mac17 = ~clear_mac17;

    // watchdog sized from the test lengths
    always @(posedge clear_mac17) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_result(input string name, input mac_result_t exp,
                                input mac_result_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected sum %h overflow %b, actual sum %h overflow %b",
                     name, exp.sum, exp.overflow, act.sum, act.overflow);
            $display("test failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected done %b, actual done %b", name, exp, act);
            $display("test failed");
            $fatal(1, "done mismatch");
        end
    endtask

    // sample mid cycle and move on to the next rising edge
    task automatic advance(input string name, input logic exp_done);
        @(negedge clear_mac17);
        check_done(name, exp_done, done);
        @(posedge clear_mac17);
    endtask

    // exact float for q/4 with q below 2^24
    function automatic logic [31:0] quarters_to_float(input int q);
        int          p;
        int          i;
        logic [31:0] m;
        logic [7:0]  e;
        if (q == 0) begin
            return 32'h0;
        end
        p = 0;
        for (i = 0; i < 24; i++) begin
            if (((q >> i) & 1) != 0) begin
                p = i;
            end
        end
        m = 32'(q) << (23 - p);
        // bias 127 minus the two fraction bits
        e = 8'(p + 125);
        return {1'b0, e, m[22:0]};
    endfunction

    task automatic build_subset_table();
        int m;
        int i;
        int q;
        for (m = 0; m < 32; m++) begin
            q = 0;
            for (i = 0; i < num_connections; i++) begin
                if (((m >> i) & 1) != 0) begin
                    q = q + set1_quarters[i];
                end
            end
            subset_sum[m] = quarters_to_float(q);
        end
    endtask

    task automatic write_entry(input int idx, input int addr, input logic [31:0] weight);
        cfg_write_t w;
        w.idx            = conn_idx_width'(idx);
        w.entry.valid    = 1'b1;
        w.entry.src_addr = addr_width'(addr);
        w.entry.weight   = weight;
        cfg_we <= 1'b1;
        cfg    <= w;
        advance("cfg_write", 1'b0);
        cfg_we <= 1'b0;
    endtask

    task automatic load_cfg(input int set);
        if (set == 1) begin
            write_entry(0, 'h010, 32'h3fc0_0000);
            write_entry(1, 'h020, 32'h4010_0000);
            write_entry(2, 'h030, 32'h3f00_0000);
            write_entry(3, 'h040, 32'h4080_0000);
            write_entry(4, 'h050, 32'h4100_0000);
            // index past the last connection is dropped by the table
            write_entry(5, 'h060, 32'h42c8_0000);
        end else begin
            // two weights of 2^127 and one zero weight
            write_entry(0, 'h010, 32'h7f00_0000);
            write_entry(1, 'h020, 32'h7f00_0000);
            write_entry(2, 'h030, 32'h0000_0000);
            write_entry(3, 'h040, 32'h4080_0000);
            write_entry(4, 'h050, 32'h4100_0000);
        end
    endtask

    task automatic add_row(input string name, input int set, input int s0, input int s1,
                           input int s2, input int s3, input int s4, input int end_addr,
                           input int busy_addr, input logic [31:0] sum, input logic ovf);
        row_name[row_total]      = name;
        row_cfg[row_total]       = set;
        row_spikes[row_total][0] = s0;
        row_spikes[row_total][1] = s1;
        row_spikes[row_total][2] = s2;
        row_spikes[row_total][3] = s3;
        row_spikes[row_total][4] = s4;
        row_end[row_total]       = end_addr;
        row_busy[row_total]      = busy_addr;
        row_exp[row_total].sum      = sum;
        row_exp[row_total].overflow = ovf;
        row_total = row_total + 1;
    endtask

    // done comes exactly 7 cycles after the timestep end edge
    task automatic run_timestep(input string name, input addr_list_t spikes,
                                input int end_addr, input int busy_addr,
                                input mac_result_t exp);
        int n;
        int i;
        for (n = 0; n < spikes.size(); n++) begin
            spike_valid  <= 1'b1;
            spike_addr   <= addr_width'(spikes[n]);
            timestep_end <= 1'b0;
            advance(name, 1'b0);
        end
        timestep_end <= 1'b1;
        spike_valid  <= (end_addr >= 0);
        spike_addr   <= addr_width'((end_addr >= 0) ? end_addr : 0);
        advance(name, 1'b0);
        for (i = 0; i <= 8; i++) begin
            // lost timestep end plus a spike for the next timestep
            if (i == 2 && busy_addr >= 0) begin
                spike_valid  <= 1'b1;
                spike_addr   <= addr_width'(busy_addr);
                timestep_end <= 1'b1;
            end else begin
                spike_valid  <= 1'b0;
                timestep_end <= 1'b0;
            end
            advance(name, i == 7);
        end
        // quiet gap catches a late second done
        repeat (4) advance(name, 1'b0);
        check_result(name, exp, result);
    endtask

    task automatic run_table();
        int         r;
        int         n;
        int         cur_set;
        addr_list_t spikes;
        cur_set = 0;
        for (r = 0; r < row_total; r++) begin
            if (row_cfg[r] != cur_set) begin
                load_cfg(row_cfg[r]);
                cur_set = row_cfg[r];
            end
            spikes.delete();
            for (n = 0; n < max_spikes; n++) begin
                if (row_spikes[r][n] >= 0) begin
                    spikes.push_back(row_spikes[r][n]);
                end
            end
            run_timestep(row_name[r], spikes, row_end[r], row_busy[r], row_exp[r]);
        end
    endtask

    task automatic run_random();
        int          k;
        int          i;
        logic [4:0]  subset;
        addr_list_t  spikes;
        mac_result_t exp;
        load_cfg(1);
        for (k = 0; k < num_random; k++) begin
            subset = 5'($random(seed));
            spikes.delete();
            for (i = 0; i < num_connections; i++) begin
                if (subset[i]) begin
                    spikes.push_back('h010 * (i + 1));
                end
            end
            exp.sum      = subset_sum[subset];
            exp.overflow = 1'b0;
            run_timestep($sformatf("random_%0d", k), spikes, -1, -1, exp);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        cfg_we       = 1'b0;
        cfg          = '0;
        spike_valid  = 1'b0;
        spike_addr   = '0;
        timestep_end = 1'b0;

        // name, cfg set, spikes, same cycle spike, busy spike, sum, overflow
        add_row("reset_empty", 0, 'h010, 'h000, -1, -1, -1, -1, -1, 32'h0000_0000, 1'b0);
        add_row("single_c0", 1, 'h010, -1, -1, -1, -1, -1, -1, 32'h3fc0_0000, 1'b0);
        add_row("single_c1", 1, 'h020, -1, -1, -1, -1, -1, -1, 32'h4010_0000, 1'b0);
        add_row("single_c2", 1, 'h030, -1, -1, -1, -1, -1, -1, 32'h3f00_0000, 1'b0);
        add_row("single_c3", 1, 'h040, -1, -1, -1, -1, -1, -1, 32'h4080_0000, 1'b0);
        add_row("single_c4", 1, 'h050, -1, -1, -1, -1, -1, -1, 32'h4100_0000, 1'b0);
        add_row("unmatched", 1, 'h060, 'h7ff, 'h011, -1, -1, -1, -1, 32'h0000_0000, 1'b0);
        add_row("multi_repeat", 1, 'h010, 'h010, 'h040, 'h010, 'h030, -1, -1,
                32'h40c0_0000, 1'b0);
        // 0x050 arrives with timestep end and belongs to the next row
        add_row("end_same_cycle", 1, 'h020, -1, -1, -1, -1, 'h050, -1, 32'h4010_0000, 1'b0);
        // 0x030 arrives with a refused timestep end
        add_row("busy_end_ignored", 1, -1, -1, -1, -1, -1, -1, 'h030, 32'h4100_0000, 1'b0);
        add_row("busy_carry", 1, 'h010, -1, -1, -1, -1, -1, -1, 32'h4000_0000, 1'b0);
        add_row("overflow", 2, 'h010, 'h020, -1, -1, -1, -1, -1, 32'h7f80_0000, 1'b1);
        add_row("zero_weight", 2, 'h030, 'h040, 'h050, -1, -1, -1, -1, 32'h4140_0000, 1'b0);
        build_subset_table();

        repeat (reset_cycles) @(posedge clear_mac17);
        rst_n <= 1'b1;
        advance("after_reset", 1'b0);
        check_result("after_reset", '0, result);

        run_table();
        run_random();

        $display("test passed");
        $finish;
    end

endmodule : snn_mac_tb

`default_nettype wire

//--- src.f
rtl/snn_cfg_pkg.sv
rtl/snn_types_pkg.sv
rtl/synapse_table.sv
rtl/spike_collector.sv
rtl/fp_adder.sv
rtl/mac_accumulator.sv
rtl/snn_mac_top.sv
verification/snn_mac_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the synapse accumulate testbench with verilator
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module snn_mac_tb -f src.f \
    -o snn_mac_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snn_mac_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

# the log decides the outcome
if grep -q "test failed" "$sim_log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "test passed" "$sim_log"; then
    echo "no pass message found in $sim_log"
    exit 1
fi
exit 0
